/* sources.f */
ecc_pkg.sv
ecc_check_if.sv
ecc_check_stage.sv
ecc_correct_stage.sv
ecc_82_top.sv
tb_ecc_82.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ECC pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_ecc_82 -f sources.f -o sim_ecc_82
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_ecc_82)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" <<< "$output"; then
    exit 0
else
    exit 1
fi

/* tb_ecc_82.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ecc_82;

    import ecc_pkg::*;

    // Cycles used by each test, flush included
    localparam int CLEAN_WORDS    = 40;
    localparam int DOUBLE_CASES   = 30;
    localparam int BYPASS_CASES   = 16;
    localparam int TEST_CYCLES    = 4 + 2 + (CLEAN_WORDS + 2) + (DATA_WIDTH + 2)
                                  + (PARITY_WIDTH + 2) + (DOUBLE_CASES + 2) + (BYPASS_CASES + 2);
    localparam int TIMEOUT_CYCLES = 1000;  // Roughly five times TEST_CYCLES

    typedef struct packed {
        data_t   data;
        parity_t parity;
        data_t   mask;
        logic    sbit;
        logic    dbit;
    } expect_t;

    logic    clk = 1'b0;
    logic    rst_n;
    data_t   data_in;
    parity_t parity_in;
    logic    bypass;
    data_t   data_out;
    parity_t parity_out;
    data_t   mask;
    logic    sbit_err;
    logic    dbit_err;

    integer  seed = 32'hf0ea2213;
    int      cycle_count = 0;
    int      data_errors = 0;
    int      parity_errors = 0;
    int      flag_errors = 0;
    expect_t pending[$];

    ecc_82_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .data_out   (data_out),
        .parity_out (parity_out),
        .mask       (mask),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // ******************************************************************
    // Reference model and random helpers
    // ******************************************************************

    // Parity bit j covers every data bit whose column has bit j set
    function automatic parity_t encode(input data_t d);
        parity_t p;
        p = '0;
        for (int j = 0; j < PARITY_WIDTH; j++) begin
            for (int i = 0; i < DATA_WIDTH; i++) begin
                if (H_COLUMNS[i][j]) begin
                    p[j] = p[j] ^ d[i];
                end
            end
        end
        return p;
    endfunction

    function automatic data_t rand_word();
        logic [95:0] r;
        r = {$random(seed), $random(seed), $random(seed)};
        return r[DATA_WIDTH-1:0];
    endfunction

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    function automatic data_t data_onehot(input int pos);
        data_t v;
        v = '0;
        v[pos] = 1'b1;
        return v;
    endfunction

    function automatic parity_t parity_onehot(input int pos);
        parity_t v;
        v = '0;
        v[pos] = 1'b1;
        return v;
    endfunction

    // ******************************************************************
    // Compare tasks
    // ******************************************************************

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("Fail %s at %0t: expected %h, got %h", name, $time, exp, act);
            data_errors++;
        end
    endtask

    task automatic check_parity(input string name, input parity_t exp, input parity_t act);
        if (act !== exp) begin
            $display("Fail %s at %0t: expected %h, got %h", name, $time, exp, act);
            parity_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s at %0t: expected %h, got %h", name, $time, exp, act);
            flag_errors++;
        end
    endtask

    task automatic compare_outputs(input expect_t exp);
        check_data("data_out", exp.data, data_out);
        check_parity("parity_out", exp.parity, parity_out);
        check_data("mask", exp.mask, mask);
        check_flag("sbit_err", exp.sbit, sbit_err);
        check_flag("dbit_err", exp.dbit, dbit_err);
    endtask

    // ******************************************************************
    // Pipeline driver
    // ******************************************************************

    // Outputs seen at a falling edge belong to the word driven two falling edges earlier
    task automatic drive_word(input data_t d, input parity_t p, input logic byp,
                              input expect_t exp);
        expect_t old;
        @(negedge clk);
        if (pending.size() == 2) begin
            old = pending.pop_front();
            compare_outputs(old);
        end
        data_in   = d;
        parity_in = p;
        bypass    = byp;
        pending.push_back(exp);
    endtask

    task automatic drain_pipeline();
        expect_t old;
        while (pending.size() > 0) begin
            @(negedge clk);
            old = pending.pop_front();
            compare_outputs(old);
            data_in   = '0;
            parity_in = '0;
            bypass    = 1'b0;
        end
    endtask

    // ******************************************************************
    // Directed tests
    // ******************************************************************

    task automatic test_after_reset();
        expect_t zero;
        zero = '0;
        repeat (2) begin
            @(negedge clk);
            compare_outputs(zero);
        end
    endtask

    task automatic test_clean_words();
        data_t   d;
        expect_t exp;
        for (int n = 0; n < CLEAN_WORDS; n++) begin
            d   = rand_word();
            exp = '{data: d, parity: encode(d), mask: '0, sbit: 1'b0, dbit: 1'b0};
            drive_word(d, encode(d), 1'b0, exp);
        end
        drain_pipeline();
    endtask

    task automatic test_data_bit_errors();
        data_t   d;
        data_t   bad;
        expect_t exp;
        for (int pos = 0; pos < DATA_WIDTH; pos++) begin
            d   = rand_word();
            bad = d ^ data_onehot(pos);
            exp = '{data: d, parity: encode(bad), mask: data_onehot(pos),
                    sbit: 1'b1, dbit: 1'b0};
            drive_word(bad, encode(d), 1'b0, exp);
        end
        drain_pipeline();
    endtask

    task automatic test_check_bit_errors();
        data_t   d;
        expect_t exp;
        for (int pos = 0; pos < PARITY_WIDTH; pos++) begin
            d   = rand_word();
            exp = '{data: d, parity: encode(d), mask: '0, sbit: 1'b1, dbit: 1'b0};
            drive_word(d, encode(d) ^ parity_onehot(pos), 1'b0, exp);
        end
        drain_pipeline();
    endtask

    // Positions below DATA_WIDTH are data bits, the rest check bits
    task automatic corrupt_two(inout data_t d, inout parity_t p);
        int a;
        int b;
        a = rand_below(DATA_WIDTH + PARITY_WIDTH);
        b = rand_below(DATA_WIDTH + PARITY_WIDTH - 1);
        if (b >= a) begin
            b++;  // Keeps the two positions distinct
        end
        foreach (d[i]) begin
            if (i == a || i == b) begin
                d[i] = ~d[i];
            end
        end
        foreach (p[j]) begin
            if (j + DATA_WIDTH == a || j + DATA_WIDTH == b) begin
                p[j] = ~p[j];
            end
        end
    endtask

    task automatic test_double_errors();
        data_t   d;
        parity_t p;
        expect_t exp;
        for (int n = 0; n < DOUBLE_CASES; n++) begin
            d = rand_word();
            p = encode(d);
            corrupt_two(d, p);
            exp = '{data: d, parity: encode(d), mask: '0, sbit: 1'b0, dbit: 1'b1};
            drive_word(d, p, 1'b0, exp);
        end
        drain_pipeline();
    endtask

    task automatic test_bypass();
        data_t   d;
        parity_t p;
        data_t   exp_mask;
        int      pos;
        expect_t exp;
        for (int n = 0; n < BYPASS_CASES; n++) begin
            d = rand_word();
            p = encode(d);
            if (n % 2 == 0) begin
                pos      = rand_below(DATA_WIDTH);
                d        = d ^ data_onehot(pos);
                exp_mask = data_onehot(pos);  // Decoded position still reported
            end else begin
                corrupt_two(d, p);
                exp_mask = '0;
            end
            exp = '{data: d, parity: encode(d), mask: exp_mask, sbit: 1'b0, dbit: 1'b0};
            drive_word(d, p, 1'b1, exp);
        end
        drain_pipeline();
    endtask

    initial begin
        rst_n     = 1'b0;
        data_in   = rand_word();  // Garbage that reset has to hold back
        parity_in = 8'hff;
        bypass    = 1'b0;
        repeat (4) @(negedge clk);
        rst_n     = 1'b1;
        data_in   = '0;
        parity_in = '0;

        test_after_reset();
        test_clean_words();
        test_data_bit_errors();
        test_check_bit_errors();
        test_double_errors();
        test_bypass();

        $display("Errors after %0d of %0d planned cycles: data %0d, parity %0d, flag %0d",
                 cycle_count, TEST_CYCLES, data_errors, parity_errors, flag_errors);
        if (data_errors + parity_errors + flag_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ecc_82_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ecc_82_top
    import ecc_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire data_t   data_in,
    input  wire parity_t parity_in,
    input  wire          bypass,
    output data_t        data_out,
    output parity_t      parity_out,
    output data_t        mask,
    output logic         sbit_err,
    output logic         dbit_err
);

    // Two-edge latency, one word per clock
    ecc_check_if chk_if ();

    ecc_check_stage i_check (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (data_in),
        .parity_in (parity_in),
        .bypass    (bypass),
        .chk       (chk_if.src)
    );

    ecc_correct_stage i_correct (
        .clk        (clk),
        .rst_n      (rst_n),
        .chk        (chk_if.dst),
        .data_out   (data_out),
        .parity_out (parity_out),
        .mask       (mask),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

endmodule

`default_nettype wire

/* ecc_correct_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module ecc_correct_stage
    import ecc_pkg::*;
(
    input  wire       clk,
    input  wire       rst_n,
    ecc_check_if.dst  chk,
    output data_t     data_out,
    output parity_t   parity_out,
    output data_t     mask,
    output logic      sbit_err,
    output logic      dbit_err
);

    data_t     dec_mask;
    logic      col_hit;
    err_kind_t err_kind;
    data_t     fixed_data;

    // ******************************************************************
    // Syndrome decode
    // ******************************************************************

    // At most one column can match since columns are distinct
    always_comb begin
        dec_mask = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            dec_mask[i] = (chk.syndrome == H_COLUMNS[i]);
        end
    end

    assign col_hit = |dec_mask;

    always_comb begin
        if (chk.syndrome == '0) begin
            err_kind = ERR_NONE;
        end else if (col_hit || $onehot(chk.syndrome)) begin
            err_kind = ERR_SINGLE;  // Data bit or check bit flipped
        end else begin
            err_kind = ERR_DOUBLE;
        end
    end

    assign fixed_data = chk.bypass ? chk.data : (chk.data ^ dec_mask);

    // ******************************************************************
    // Output register
    // ******************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out   <= '0;
            parity_out <= '0;
            mask       <= '0;
            sbit_err   <= 1'b0;
            dbit_err   <= 1'b0;
        end else begin
            data_out   <= fixed_data;
            parity_out <= chk.parity;
            mask       <= dec_mask;  // Reported even in bypass
            sbit_err   <= !chk.bypass && (err_kind == ERR_SINGLE);
            dbit_err   <= !chk.bypass && (err_kind == ERR_DOUBLE);
        end
    end

endmodule

`default_nettype wire

/* ecc_check_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module ecc_check_stage
    import ecc_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire data_t   data_in,
    input  wire parity_t parity_in,
    input  wire          bypass,
    ecc_check_if.src     chk
);

    parity_t enc_parity;

    // ******************************************************************
    // Encoder
    // ******************************************************************

    // Each set data bit folds its column into the parity
    always_comb begin
        enc_parity = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            enc_parity = enc_parity ^ (H_COLUMNS[i] & {PARITY_WIDTH{data_in[i]}});
        end
    end

    // ******************************************************************
    // Stage register
    // ******************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chk.data     <= '0;
            chk.parity   <= '0;
            chk.syndrome <= '0;
            chk.bypass   <= 1'b0;
        end else begin
            chk.data     <= data_in;
            chk.parity   <= enc_parity;
            chk.syndrome <= enc_parity ^ parity_in;  // Zero when consistent
            chk.bypass   <= bypass;
        end
    end

endmodule

`default_nettype wire

/* ecc_check_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface ecc_check_if
    import ecc_pkg::*;
();

    data_t   data;      // Raw word as received
    parity_t parity;    // Parity re-encoded from data
    parity_t syndrome;  // Received parity vs. re-encoded
    logic    bypass;

    modport src (
        output data,
        output parity,
        output syndrome,
        output bypass
    );

    modport dst (
        input  data,
        input  parity,
        input  syndrome,
        input  bypass
    );

endinterface

`default_nettype wire

/* ecc_pkg.sv */
`default_nettype none

package ecc_pkg;

    // ******************************************************************
    // Widths and word types
    // ******************************************************************

    localparam int DATA_WIDTH   = 82;
    localparam int PARITY_WIDTH = 8;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [PARITY_WIDTH-1:0] parity_t;

    // ******************************************************************
    // Check matrix, one column per data bit
    // ******************************************************************

    // Odd weight, all distinct, weight 3 or more
    localparam parity_t [DATA_WIDTH-1:0] H_COLUMNS = '{
        8'b11011001,  // Bit 81
        8'b01011000,
        8'b01010111,
        8'b11010110,
        8'b11010101,
        8'b01010100,
        8'b11010011,
        8'b01010010,
        8'b01010001,
        8'b11010000,
        8'b01001111,  // Bit 71
        8'b11001110,
        8'b11001101,
        8'b01001100,
        8'b11001011,
        8'b01001010,
        8'b01001001,
        8'b11001000,
        8'b11000111,
        8'b01000110,
        8'b01000101,  // Bit 61
        8'b11000100,
        8'b01000011,
        8'b11000010,
        8'b11000001,  // Start of p[6] group
        8'b10111111,
        8'b00111110,
        8'b00111101,
        8'b10111100,
        8'b00111011,
        8'b10111010,  // Bit 51
        8'b10111001,
        8'b00111000,
        8'b00110111,
        8'b10110110,
        8'b10110101,
        8'b00110100,
        8'b10110011,
        8'b00110010,
        8'b00110001,
        8'b10110000,  // Bit 41
        8'b00101111,
        8'b10101110,
        8'b10101101,
        8'b00101100,
        8'b10101011,
        8'b00101010,
        8'b00101001,
        8'b10101000,
        8'b10100111,
        8'b00100110,  // Bit 31
        8'b00100101,
        8'b10100100,
        8'b00100011,
        8'b10100010,
        8'b10100001,  // Start of p[5] group
        8'b00011111,
        8'b10011110,
        8'b10011101,
        8'b00011100,
        8'b10011011,  // Bit 21
        8'b00011010,
        8'b00011001,
        8'b10011000,
        8'b10010111,
        8'b00010110,
        8'b00010101,
        8'b10010100,
        8'b00010011,
        8'b10010010,
        8'b10010001,  // Bit 11
        8'b10001111,
        8'b00001110,
        8'b00001101,
        8'b10001100,
        8'b00001011,
        8'b10001010,
        8'b10001001,
        8'b00000111,
        8'b10000110,
        8'b10000101,
        8'b10000011   // Bit 0
    };

    // ******************************************************************
    // Error classification
    // ******************************************************************

    typedef enum logic [1:0] {
        ERR_NONE,    // Syndrome zero
        ERR_SINGLE,  // Data column or lone check bit
        ERR_DOUBLE   // Anything else
    } err_kind_t;

endpackage

`default_nettype wire
